// ==== gzip_stored_top.f ====
+incdir+.
gzip_format_pkg.sv
gzip_ctrl_pkg.sv
sync_fifo.sv
crc32_unit.sv
block_parser.sv
frame_writer.sv
out_arbiter.sv
gzip_stored_top.sv
gzip_asserts.sv
gzip_scoreboard.sv
tb_gzip_stored.sv

// ==== Bender.yml ====
package:
  name: gzip_stored

export_include_dirs:
  - .

sources:
  - files:
      - gzip_format_pkg.sv
      - gzip_ctrl_pkg.sv
      - sync_fifo.sv
      - crc32_unit.sv
      - block_parser.sv
      - frame_writer.sv
      - out_arbiter.sv
      - gzip_stored_top.sv
  - target: test
    files:
      - gzip_asserts.sv
      - gzip_scoreboard.sv
      - tb_gzip_stored.sv

// ==== tb_gzip_stored.sv ====
//==========================================================================
// testbench for the stored-block gzip encoder, random blocks vs a model
//==========================================================================
`timescale 1ns/1ps

module tb_gzip_stored;
	localparam int CLK_PERIOD = 20;
	localparam int ROUNDS     = 3;

	logic                    clk;
	logic                    rst_n;
	gzip_format_pkg::btype_e btype;
	logic                    in_wr_en;
	logic [31:0]             in_data;
	logic                    in_full;
	logic                    out_rd_en;
	logic [7:0]              out_data;
	logic                    out_empty;
	gzip_ctrl_pkg::status_t  status;
	logic                    irq;

	logic [31:0] rng_state;
	logic [31:0] words [$];
	int          exp_count;
	time         deadline;

	gzip_stored_top i_dut (
		.clk, .rst_n, .btype,
		.in_wr_en, .in_data, .in_full,
		.out_rd_en, .out_data, .out_empty,
		.status, .irq
	);

	// compares the output byte stream, irq and status per test
	gzip_scoreboard i_sb (
		.clk, .rst_n, .in_full, .out_rd_en, .out_data, .out_empty, .irq, .status
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// xorshift32
	function automatic logic [31:0] rand_next();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// reference crc32, bit-serial lfsr, lsb of the byte first
	function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			r = (r >> 1) ^ ({32{r[0] ^ b[i]}} & 32'hedb88320);
		end
		return r;
	endfunction

	task automatic push_expected(input logic [7:0] b);
		i_sb.expect_byte(b);
		exp_count++;
	endtask

	task automatic apply_reset();
		rst_n     = 1'b0;
		in_wr_en  = 1'b0;
		in_data   = '0;
		out_rd_en = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
	endtask

	//==========================================================================
	// one test
	// kind 0 single block, 1 several blocks, 2 several blocks with read
	// stalls, 3 non-stored btype, 4 oversized stored block
	//==========================================================================
	task automatic run_test(input string name, input int kind);
		int                        n_blk;
		int                        len;
		int                        quiet;
		logic [31:0]               crc;
		logic [31:0]               isize;
		logic [31:0]               word;
		logic [7:0]                b;
		gzip_format_pkg::blk_hdr_t h;
		gzip_ctrl_pkg::status_t    exp_status;
		deadline  = $time + 100 * CLK_PERIOD;
		exp_count = 0;
		quiet     = 0;
		crc       = '1;
		isize     = '0;
		words.delete();
		i_sb.start_test(name);
		btype = gzip_format_pkg::bt_stored;
		// non-stored types are fixed, dynamic or reserved
		if (kind == 3) begin
			btype = gzip_format_pkg::btype_e'(2'(32'd1 + (rand_next() % 32'd3)));
		end
		apply_reset();
		i_sb.check_reset_values();
		n_blk = (kind == 1 || kind == 2) ? 2 + int'(rand_next() % 32'd3) : 1;
		// gzip member header once per stream
		if (kind < 3) begin
			push_expected(8'h1f);
			push_expected(8'h8b);
			push_expected(8'h08);
			for (int i = 0; i < 6; i++) begin
				push_expected(8'h00);
			end
			push_expected(8'h03);
		end
		for (int blk = 0; blk < n_blk; blk++) begin
			// longer blocks with stalls so the output fifo backs up
			len      = int'(rand_next() % ((kind == 2) ? 32'd121 : 32'd41));
			h.rsvd   = '0;
			h.bfinal = (blk == n_blk - 1);
			h.len    = 24'(len);
			if (kind == 4) begin
				h.len = 24'(32'd65536 + (rand_next() % 32'd16711680));
			end
			words.push_back(h);
			if (kind < 3) begin
				push_expected({7'b0000000, h.bfinal});
				push_expected(len[7:0]);
				push_expected(len[15:8]);
				push_expected(~len[7:0]);
				push_expected(~len[15:8]);
			end
			// payload packed little-endian, last word padded
			word = '0;
			for (int i = 0; (kind != 4) && (i < len); i++) begin
				b = 8'(rand_next() >> 8);
				word[8*(i%4) +: 8] = b;
				if (kind < 3) begin
					push_expected(b);
					crc   = crc_update(crc, b);
					isize = isize + 32'd1;
				end
				if ((i % 4 == 3) || (i == len - 1)) begin
					words.push_back(word);
					word = '0;
				end
			end
		end
		// trailer, crc32 then isize, lsb first
		if (kind < 3) begin
			for (int i = 0; i < 4; i++) begin
				push_expected(8'(~crc >> (8*i)));
			end
			for (int i = 0; i < 4; i++) begin
				push_expected(8'(isize >> (8*i)));
			end
		end
		exp_status = '{done: (kind < 3), bsize_err: (kind == 4), btype_err: (kind == 3)};
		deadline = $time + ((words.size() + exp_count) * 8 + 300) * CLK_PERIOD;
		forever begin
			@(negedge clk);
			if (kind < 3 && status.done && out_empty && words.size() == 0 &&
				i_sb.pending() == 0) begin
				break;
			end
			// after an error the output must stay silent for a while
			if (kind >= 3 && (status.btype_err || status.bsize_err) && words.size() == 0) begin
				quiet++;
			end
			if (quiet > 20) begin
				break;
			end
			if (words.size() > 0 && !in_full) begin
				in_wr_en = 1'b1;
				in_data  = words.pop_front();
			end else begin
				in_wr_en = 1'b0;
			end
			out_rd_en = (kind == 2) ? ((rand_next() % 32'd4) == 0) : 1'b1;
		end
		in_wr_en  = 1'b0;
		out_rd_en = 1'b0;
		i_sb.finish_test(exp_status);
	endtask

	initial begin
		rng_state = 32'h263a_b0c2;
		deadline  = 100 * CLK_PERIOD;
		exp_count = 0;
		rst_n     = 1'b0;
		btype     = gzip_format_pkg::bt_stored;
		in_wr_en  = 1'b0;
		in_data   = '0;
		out_rd_en = 1'b0;
		for (int r = 0; r < ROUNDS; r++) begin
			run_test($sformatf("single_block_%0d", r), 0);
			run_test($sformatf("multi_block_%0d", r), 1);
			run_test($sformatf("stalled_output_%0d", r), 2);
			run_test($sformatf("bad_btype_%0d", r), 3);
			run_test($sformatf("bad_bsize_%0d", r), 4);
		end
		$display("tests passed %0d, tests failed %0d, assertion failures %0d",
			i_sb.tests_passed, i_sb.tests_failed, i_dut.i_asserts.fail_count);
		if (i_sb.tests_failed == 0 && i_dut.i_asserts.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// deadline is moved forward by each test from its own length
	initial begin
		@(posedge clk);
		while ($time <= deadline) begin
			@(posedge clk);
		end
		$display("error: timeout in test %s, the DUT did not finish in time",
			i_sb.test_name);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== gzip_scoreboard.sv ====
//==========================================================================
// scoreboard: checks popped output bytes, irq pulses and final status
//==========================================================================
`timescale 1ns/1ps

module gzip_scoreboard (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   in_full,
	input logic                   out_rd_en,
	input logic [7:0]             out_data,
	input logic                   out_empty,
	input logic                   irq,
	input gzip_ctrl_pkg::status_t status
);
	logic [7:0] exp_q [$];
	logic [7:0] exp_b;
	string      test_name;
	int         byte_idx;
	int         test_errs;
	int         irq_count;
	int         tests_passed;
	int         tests_failed;

	initial begin
		test_name    = "none";
		byte_idx     = 0;
		test_errs    = 0;
		irq_count    = 0;
		tests_passed = 0;
		tests_failed = 0;
	end

	task automatic start_test(input string name);
		test_name = name;
		exp_q.delete();
		byte_idx  = 0;
		test_errs = 0;
		irq_count = 0;
	endtask

	task automatic expect_byte(input logic [7:0] b);
		exp_q.push_back(b);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	// right after reset: flags clear, irq low, input open, output empty
	task automatic check_reset_values();
		if (status !== 3'b000) begin
			$display("Mismatch test %s reset status expected 000 actual %03b",
				test_name, status);
			test_errs++;
		end
		if (irq !== 1'b0) begin
			$display("Mismatch test %s reset irq expected 0 actual %0b", test_name, irq);
			test_errs++;
		end
		if (in_full !== 1'b0) begin
			$display("Mismatch test %s reset in_full expected 0 actual %0b",
				test_name, in_full);
			test_errs++;
		end
		if (out_empty !== 1'b1) begin
			$display("Mismatch test %s reset out_empty expected 1 actual %0b",
				test_name, out_empty);
			test_errs++;
		end
	endtask

	// a pop happens on a rising edge with rd_en high and fifo not empty
	always @(posedge clk) begin
		if (rst_n) begin
			if (irq) begin
				irq_count++;
			end
			if (out_rd_en && !out_empty) begin
				if (exp_q.size() == 0) begin
					$display("error: test %s read byte %0d (0x%02h) beyond the expected stream",
						test_name, byte_idx, out_data);
					test_errs++;
				end else begin
					exp_b = exp_q.pop_front();
					if (out_data !== exp_b) begin
						$display("Mismatch test %s byte %0d expected 0x%02h actual 0x%02h",
							test_name, byte_idx, exp_b, out_data);
						test_errs++;
					end
				end
				byte_idx++;
			end
		end
	end

	task automatic finish_test(input gzip_ctrl_pkg::status_t exp_status);
		if (exp_q.size() != 0) begin
			$display("error: test %s ended with %0d expected bytes never read",
				test_name, exp_q.size());
			test_errs++;
		end
		if (irq_count != 1) begin
			$display("error: test %s saw %0d irq pulses instead of one", test_name, irq_count);
			test_errs++;
		end
		// status bits are done, bsize_err, btype_err
		if (status !== exp_status) begin
			$display("Mismatch test %s status expected %03b actual %03b",
				test_name, exp_status, status);
			test_errs++;
		end
		if (test_errs == 0) begin
			tests_passed++;
			$display("test %s passed, %0d bytes", test_name, byte_idx);
		end else begin
			tests_failed++;
			$display("test %s failed, %0d errors", test_name, test_errs);
		end
	endtask

endmodule

// ==== gzip_asserts.sv ====
//==========================================================================
// protocol assertions bound into the encoder top level
//==========================================================================
`timescale 1ns/1ps

module gzip_asserts (
	input logic clk,
	input logic rst_n,
	input logic irq,
	input logic frame_gnt,
	input logic payload_gnt,
	input logic btype_err,
	input logic bsize_err
);
	int fail_count;

	initial begin
		fail_count = 0;
	end

	// irq is a single-cycle pulse
	irq_pulse: assert property (@(posedge clk) disable iff (!rst_n) irq |=> !irq)
		else begin
			$error("irq stayed high for more than one cycle");
			fail_count++;
		end

	// one writer per cycle into the output fifo
	one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(frame_gnt && payload_gnt))
		else begin
			$error("frame and payload grants in the same cycle");
			fail_count++;
		end

	// a header fails on one check only
	one_error: assert property (@(posedge clk) disable iff (!rst_n)
		!($rose(btype_err) && $rose(bsize_err)))
		else begin
			$error("btype_err and bsize_err rose together");
			fail_count++;
		end

endmodule

bind gzip_stored_top gzip_asserts i_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.irq(irq),
	.frame_gnt(frame_gnt),
	.payload_gnt(payload_gnt),
	.btype_err(btype_err),
	.bsize_err(bsize_err)
);

// ==== gzip_stored_top.sv ====
//==========================================================================
// gzip encoder top level, stored deflate blocks only
//==========================================================================
`timescale 1ns/1ps
`include "gzip_macros.svh"

module gzip_stored_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  gzip_format_pkg::btype_e btype,
	input  logic                    in_wr_en,
	input  logic [31:0]             in_data,
	output logic                    in_full,
	input  logic                    out_rd_en,
	output logic [7:0]              out_data,
	output logic                    out_empty,
	output gzip_ctrl_pkg::status_t  status,
	output logic                    irq
);
	logic [31:0]               in_word;
	logic                      in_empty;
	logic                      in_rd;
	logic                      blk_start;
	gzip_format_pkg::blk_hdr_t hdr;
	logic                      frame_busy;
	gzip_ctrl_pkg::byte_req_t  frame_req;
	gzip_ctrl_pkg::byte_req_t  payload_req;
	logic                      frame_gnt;
	logic                      payload_gnt;
	logic                      final_done;
	logic                      bsize_err;
	logic                      btype_err;
	logic                      done;
	logic [31:0]               crc;
	logic [31:0]               isize;
	logic                      out_wr;
	logic [7:0]                out_byte;
	logic                      out_full;
	gzip_ctrl_pkg::status_t    status_q;

	//==========================================================================
	// input side
	//==========================================================================
	sync_fifo #(.WIDTH(32), .DEPTH(`GZ_IN_DEPTH)) i_in_fifo (
		.clk, .rst_n,
		.wr_en(in_wr_en), .wr_data(in_data),
		.rd_en(in_rd), .rd_data(in_word),
		.full(in_full), .empty(in_empty)
	);

	block_parser i_parser (
		.clk, .rst_n, .btype,
		.fifo_data(in_word), .fifo_empty(in_empty), .fifo_rd(in_rd),
		.blk_start, .hdr, .frame_busy,
		.req(payload_req), .gnt(payload_gnt),
		.final_done, .bsize_err, .btype_err
	);

	// checksum covers granted payload bytes only
	crc32_unit i_crc (
		.clk, .rst_n, .upd(payload_gnt), .data(payload_req.data), .crc, .isize
	);

	//==========================================================================
	// output side
	//==========================================================================
	frame_writer i_frame (
		.clk, .rst_n, .blk_start, .hdr, .final_done, .crc, .isize,
		.req(frame_req), .gnt(frame_gnt), .busy(frame_busy), .done
	);

	out_arbiter i_arb (
		.frame_req, .payload_req, .fifo_full(out_full),
		.frame_gnt, .payload_gnt, .fifo_wr(out_wr), .fifo_data(out_byte)
	);

	sync_fifo #(.WIDTH(8), .DEPTH(`GZ_OUT_DEPTH)) i_out_fifo (
		.clk, .rst_n,
		.wr_en(out_wr), .wr_data(out_byte),
		.rd_en(out_rd_en), .rd_data(out_data),
		.full(out_full), .empty(out_empty)
	);

	// status flags are sticky until reset
	assign status = '{done: done, bsize_err: bsize_err, btype_err: btype_err};

	// irq marks the first cycle of any newly set flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status_q <= '0;
		end else begin
			status_q <= status;
		end
	end

	assign irq = |(status & ~status_q);

endmodule

// ==== out_arbiter.sv ====
//==========================================================================
// output arbiter, frame writer ahead of payload, gated by fifo full
//==========================================================================
`timescale 1ns/1ps

module out_arbiter (
	input  gzip_ctrl_pkg::byte_req_t frame_req,
	input  gzip_ctrl_pkg::byte_req_t payload_req,
	input  logic                     fifo_full,
	output logic                     frame_gnt,
	output logic                     payload_gnt,
	output logic                     fifo_wr,
	output logic [7:0]               fifo_data
);
	// nothing is granted while the output fifo is full
	assign frame_gnt   = frame_req.valid && !fifo_full;
	// payload only when the frame writer is silent
	assign payload_gnt = payload_req.valid && !frame_req.valid && !fifo_full;

	// grant and fifo write happen in the same cycle
	assign fifo_wr   = frame_gnt || payload_gnt;
	assign fifo_data = frame_req.valid ? frame_req.data : payload_req.data;

endmodule

// ==== frame_writer.sv ====
//==========================================================================
// frame writer: gzip member header, stored block headers and trailer
//==========================================================================
`timescale 1ns/1ps
`include "gzip_macros.svh"

module frame_writer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      blk_start,
	input  gzip_format_pkg::blk_hdr_t hdr,
	input  logic                      final_done,
	input  logic [31:0]               crc,
	input  logic [31:0]               isize,
	output gzip_ctrl_pkg::byte_req_t  req,
	input  logic                      gnt,
	output logic                      busy,
	output logic                      done
);
	gzip_ctrl_pkg::frame_state_e state;
	logic [3:0]                  idx;
	logic [15:0]                 len;
	logic                        bfinal;
	logic                        hdr_sent;
	logic [31:0]                 trl_word;
	logic [7:0]                  out_byte;
	logic                        last_idx;

	// trailer is crc then isize, each lsb first
	assign trl_word = idx[2] ? isize : crc;

	// byte selection per state
	always_comb begin
		out_byte = 8'h00;
		last_idx = 1'b0;
		case (state)
			gzip_ctrl_pkg::fs_gzip_hdr: begin
				last_idx = (idx == 4'd9);
				case (idx)
					4'd0:    out_byte = `GZ_HDR_BYTE0;
					4'd1:    out_byte = `GZ_HDR_BYTE1;
					4'd2:    out_byte = `GZ_HDR_BYTE2;
					4'd3:    out_byte = `GZ_HDR_BYTE3;
					4'd4:    out_byte = `GZ_HDR_BYTE4;
					4'd5:    out_byte = `GZ_HDR_BYTE5;
					4'd6:    out_byte = `GZ_HDR_BYTE6;
					4'd7:    out_byte = `GZ_HDR_BYTE7;
					4'd8:    out_byte = `GZ_HDR_BYTE8;
					default: out_byte = `GZ_HDR_BYTE9;
				endcase
			end
			gzip_ctrl_pkg::fs_blk_hdr: begin
				last_idx = (idx == 4'd4);
				// bfinal in bit 0, btype 00, padded to the byte boundary
				case (idx)
					4'd0:    out_byte = {7'b0000000, bfinal};
					4'd1:    out_byte = len[7:0];
					4'd2:    out_byte = len[15:8];
					4'd3:    out_byte = ~len[7:0];
					default: out_byte = ~len[15:8];
				endcase
			end
			gzip_ctrl_pkg::fs_trailer: begin
				last_idx = (idx == 4'd7);
				out_byte = trl_word[{idx[1:0], 3'b000} +: 8];
			end
			default: begin
				out_byte = 8'h00;
				last_idx = 1'b0;
			end
		endcase
	end

	// busy while any byte is still to be written
	assign busy = (state == gzip_ctrl_pkg::fs_gzip_hdr) || (state == gzip_ctrl_pkg::fs_blk_hdr) ||
		(state == gzip_ctrl_pkg::fs_trailer);
	assign req  = '{valid: busy, data: out_byte};
	assign done = (state == gzip_ctrl_pkg::fs_done);

	// block fields captured with blk_start
	always_ff @(posedge clk) begin
		if (blk_start) begin
			len    <= hdr.len[15:0];
			bfinal <= hdr.bfinal;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= gzip_ctrl_pkg::fs_idle;
			idx      <= '0;
			hdr_sent <= 1'b0;
		end else begin
			case (state)
				gzip_ctrl_pkg::fs_idle: begin
					idx <= 4'd0;
					// member header only ahead of the first block
					if (blk_start) begin
						state <= hdr_sent ? gzip_ctrl_pkg::fs_blk_hdr : gzip_ctrl_pkg::fs_gzip_hdr;
					end else if (final_done) begin
						state <= gzip_ctrl_pkg::fs_trailer;
					end
				end
				gzip_ctrl_pkg::fs_done: state <= gzip_ctrl_pkg::fs_done;
				default: begin
					if (gnt && last_idx) begin
						idx <= 4'd0;
						case (state)
							gzip_ctrl_pkg::fs_gzip_hdr: begin
								hdr_sent <= 1'b1;
								state    <= gzip_ctrl_pkg::fs_blk_hdr;
							end
							gzip_ctrl_pkg::fs_blk_hdr: state <= gzip_ctrl_pkg::fs_idle;
							default:                   state <= gzip_ctrl_pkg::fs_done;
						endcase
					end else if (gnt) begin
						idx <= idx + 4'd1;
					end
				end
			endcase
		end
	end

endmodule

// ==== block_parser.sv ====
//==========================================================================
// block parser: validates host header words and streams payload bytes
//==========================================================================
`timescale 1ns/1ps
`include "gzip_macros.svh"

module block_parser (
	input  logic                      clk,
	input  logic                      rst_n,
	input  gzip_format_pkg::btype_e   btype,
	input  logic [31:0]               fifo_data,
	input  logic                      fifo_empty,
	output logic                      fifo_rd,
	output logic                      blk_start,
	output gzip_format_pkg::blk_hdr_t hdr,
	input  logic                      frame_busy,
	output gzip_ctrl_pkg::byte_req_t  req,
	input  logic                      gnt,
	output logic                      final_done,
	output logic                      bsize_err,
	output logic                      btype_err
);
	gzip_ctrl_pkg::parser_state_e state;
	gzip_format_pkg::blk_hdr_t    hw;
	logic [15:0]                  remain;
	logic [1:0]                   lane;
	logic                         last_blk;
	logic                         hdr_take;
	logic                         bad_type;
	logic                         bad_size;
	logic                         word_done;

	// head of input fifo seen as a block header
	assign hw  = fifo_data;
	assign hdr = hw;

	// header word is consumed in the header state
	assign hdr_take = (state == gzip_ctrl_pkg::ps_header) && !fifo_empty;
	// only stored blocks are supported here
	assign bad_type = (btype != gzip_format_pkg::bt_stored);
	assign bad_size = (hw.len > 24'(`GZ_MAX_STORED_LEN));
	// frame writer latches hdr on this pulse
	assign blk_start = hdr_take && !bad_type && !bad_size;

	// little-endian lanes, byte 0 in bits 7..0
	assign req = '{
		valid: (state == gzip_ctrl_pkg::ps_payload) && !fifo_empty,
		data:  fifo_data[{lane, 3'b000} +: 8]
	};

	// word is used up after lane 3, or early on the last byte of the block
	assign word_done = (lane == 2'd3) || (remain == 16'd1);
	assign fifo_rd   = hdr_take || (gnt && word_done);

	assign final_done = (state == gzip_ctrl_pkg::ps_final);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= gzip_ctrl_pkg::ps_idle;
			remain    <= '0;
			lane      <= '0;
			last_blk  <= 1'b0;
			bsize_err <= 1'b0;
			btype_err <= 1'b0;
		end else begin
			case (state)
				gzip_ctrl_pkg::ps_idle: begin
					if (!fifo_empty) begin
						state <= gzip_ctrl_pkg::ps_header;
					end
				end
				gzip_ctrl_pkg::ps_header: begin
					if (hdr_take) begin
						// type error takes precedence over size error
						if (bad_type) begin
							btype_err <= 1'b1;
							state     <= gzip_ctrl_pkg::ps_halt;
						end else if (bad_size) begin
							bsize_err <= 1'b1;
							state     <= gzip_ctrl_pkg::ps_halt;
						end else begin
							remain   <= hw.len[15:0];
							last_blk <= hw.bfinal;
							lane     <= 2'd0;
							state    <= gzip_ctrl_pkg::ps_wait_frame;
						end
					end
				end
				gzip_ctrl_pkg::ps_wait_frame: begin
					// block header must be out before the payload
					if (!frame_busy) begin
						if (remain != 16'd0) begin
							state <= gzip_ctrl_pkg::ps_payload;
						end else if (last_blk) begin
							state <= gzip_ctrl_pkg::ps_final;
						end else begin
							state <= gzip_ctrl_pkg::ps_idle;
						end
					end
				end
				gzip_ctrl_pkg::ps_payload: begin
					if (gnt) begin
						remain <= remain - 16'd1;
						lane   <= lane + 2'd1;
						if (remain == 16'd1) begin
							state <= last_blk ? gzip_ctrl_pkg::ps_final : gzip_ctrl_pkg::ps_idle;
						end
					end
				end
				// one cycle of final_done, then stop until reset
				gzip_ctrl_pkg::ps_final: state <= gzip_ctrl_pkg::ps_halt;
				default:                 state <= gzip_ctrl_pkg::ps_halt;
			endcase
		end
	end

endmodule

// ==== crc32_unit.sv ====
//==========================================================================
// gzip crc32 and isize accumulator, one byte per update
//==========================================================================
`timescale 1ns/1ps
`include "gzip_macros.svh"

module crc32_unit (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        upd,
	input  logic [7:0]  data,
	output logic [31:0] crc,
	output logic [31:0] isize
);
	logic [31:0] crc_q;
	logic [31:0] crc_next;

	// reflected crc, data enters at the lsb end
	// loop unrolls into eight shift and conditional xor stages
	always_comb begin
		crc_next = crc_q ^ {24'h000000, data};
		for (int i = 0; i < 8; i++) begin
			crc_next = crc_next[0] ? ((crc_next >> 1) ^ `GZ_CRC_POLY) : (crc_next >> 1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// preset to all ones
			crc_q <= '1;
			isize <= '0;
		end else if (upd) begin
			crc_q <= crc_next;
			// wraps modulo 2^32 as gzip requires
			isize <= isize + 32'd1;
		end
	end

	// final xor with all ones
	assign crc = ~crc_q;

endmodule

// ==== sync_fifo.sv ====
//==========================================================================
// synchronous first-word-fall-through fifo
//==========================================================================
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             full,
	output logic             empty
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic             do_wr;
	logic             do_rd;

	// writes into a full fifo and reads from an empty one are dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// flags come from the occupancy count
	assign full  = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);

	// head of queue is always visible
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap at DEPTH-1, so any depth works
			if (do_wr) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== gzip_ctrl_pkg.sv ====
//==========================================================================
// internal control types of the stored encoder
// fsm state encodings, byte request and status flags
//==========================================================================
package gzip_ctrl_pkg;

	// block parser fsm
	typedef enum logic [2:0] {
		ps_idle,
		ps_header,
		ps_wait_frame,
		ps_payload,
		ps_final,
		ps_halt
	} parser_state_e;

	// frame writer fsm
	typedef enum logic [2:0] {
		fs_idle,
		fs_gzip_hdr,
		fs_blk_hdr,
		fs_trailer,
		fs_done
	} frame_state_e;

	// one byte offered to the output arbiter, held until granted
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} byte_req_t;

	// level status flags seen by the host
	typedef struct packed {
		logic done;
		logic bsize_err;
		logic btype_err;
	} status_t;

endpackage

// ==== gzip_format_pkg.sv ====
//==========================================================================
// deflate and gzip format types
// block type encoding and the layout of the host block header word
//==========================================================================
package gzip_format_pkg;

	// deflate BTYPE field, as written in bits 2..1 of a block header
	typedef enum logic [1:0] {
		bt_stored   = 2'b00,
		bt_fixed    = 2'b01,
		bt_dynamic  = 2'b10,
		bt_reserved = 2'b11
	} btype_e;

	// first word of every block from the host
	// len counts payload bytes, the payload words follow rounded up
	typedef struct packed {
		logic [6:0]  rsvd;
		logic        bfinal;
		logic [23:0] len;
	} blk_hdr_t;

endpackage

// ==== gzip_macros.svh ====
//==========================================================================
// gzip stored encoder constants
// fifo depths, gzip member header bytes, crc polynomial, stored length limit
//==========================================================================
`ifndef GZIP_MACROS_SVH
`define GZIP_MACROS_SVH

// input fifo depth in 32-bit words
`define GZ_IN_DEPTH 16
// output fifo depth in bytes
`define GZ_OUT_DEPTH 32

// largest LEN field a stored block can carry
`define GZ_MAX_STORED_LEN 65535

// reflected ieee 802.3 polynomial, lsb first
`define GZ_CRC_POLY 32'hedb88320

// gzip member header: id1 id2 cm flg, mtime (4 bytes), xfl, os (unix)
`define GZ_HDR_BYTE0 8'h1f
`define GZ_HDR_BYTE1 8'h8b
`define GZ_HDR_BYTE2 8'h08
`define GZ_HDR_BYTE3 8'h00
`define GZ_HDR_BYTE4 8'h00
`define GZ_HDR_BYTE5 8'h00
`define GZ_HDR_BYTE6 8'h00
`define GZ_HDR_BYTE7 8'h00
`define GZ_HDR_BYTE8 8'h00
`define GZ_HDR_BYTE9 8'h03

`endif
